//--- hw/fetch_pkg.sv
////////////////////////////////////////
// Address layout and sizes shared by the fetch unit and its cache
// RTL files refer to these by scoped name
////////////////////////////////////////

`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Core fetch address and Wishbone address
    localparam int addr_w = 32;
    // One instruction word per cache line
    localparam int data_w = 32;

    // Byte offset inside a word, never looked at
    localparam int offset_w = 2;
    // 16 lines, direct mapped
    localparam int index_w = 4;
    localparam int tag_w = addr_w - index_w - offset_w;
    localparam int lines = 1 << index_w;

    // Outstanding requests ahead of lookup
    // Kept a power of two, the FIFO count relies on it
    localparam int req_depth = 4;

    ////////////////////////////////////////
    // Fetch address, flat or split
    ////////////////////////////////////////

    // Flat word goes to the bus, fields index the arrays
    typedef union packed {
        logic [addr_w-1:0] word;
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] offset;
        } fields;
    } fetch_addr_t;

endpackage

`default_nettype wire

//--- hw/cache_fill_if.sv
////////////////////////////////////////
// Miss request from lookup to refill and the word that comes back
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface cache_fill_if;

    // Miss side, held by lookup until the fill pulse
    logic                         miss_valid;
    logic [fetch_pkg::addr_w-1:0] miss_addr;

    // Fill side, a single cycle pulse with the fetched word
    logic                         fill_valid;
    logic [fetch_pkg::data_w-1:0] fill_data;

    // Lookup stage raises the miss and takes the fill
    modport lookup (
        output miss_valid,
        output miss_addr,
        input  fill_valid,
        input  fill_data
    );

    // Refill stage answers one miss at a time
    modport refill (
        input  miss_valid,
        input  miss_addr,
        output fill_valid,
        output fill_data
    );

endinterface

`default_nettype wire

//--- hw/fetch_req_buffer.sv
////////////////////////////////////////
// Request FIFO between the core fetch port and the cache lookup
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fetch_req_buffer (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         flush,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  logic [fetch_pkg::addr_w-1:0] req_addr,
    output logic                         head_valid,
    output logic [fetch_pkg::addr_w-1:0] head_addr,
    input  logic                         pop
);

    // Storage, pointers and fill level
    logic [fetch_pkg::addr_w-1:0]            mem [fetch_pkg::req_depth];
    logic [$clog2(fetch_pkg::req_depth)-1:0] wr_ptr;
    logic [$clog2(fetch_pkg::req_depth)-1:0] rd_ptr;
    logic [$clog2(fetch_pkg::req_depth):0]   count;
    // Low for the first cycle out of reset
    logic                                    live;
    logic                                    full;
    logic                                    push;

    // Count reaches depth exactly when its top bit sets
    assign full = count[$clog2(fetch_pkg::req_depth)];
    assign req_ready = live && !full && !flush;
    assign push = req_valid && req_ready;

    assign head_valid = (count != '0);
    assign head_addr = mem[rd_ptr];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            live <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            live <= 1'b1;
            if (flush) begin
                // Drop everything still queued
                wr_ptr <= '0;
                rd_ptr <= '0;
                count <= '0;
            end else begin
                if (push) wr_ptr <= wr_ptr + 1'b1;
                if (pop) rd_ptr <= rd_ptr + 1'b1;
                case ({push, pop})
                    2'b10: count <= count + 1'b1;
                    2'b01: count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    // Address words themselves
    always_ff @(posedge aclk) begin
        if (push) mem[wr_ptr] <= req_addr;
    end

    // Lookup never pops an empty FIFO
    assert property (@(posedge aclk) disable iff (!aresetn) pop |-> head_valid);
    // Nothing gets written over a full FIFO so the level never passes the depth
    assert property (@(posedge aclk) disable iff (!aresetn)
        count <= fetch_pkg::req_depth);

endmodule

`default_nettype wire

//--- hw/icache_lookup.sv
////////////////////////////////////////
// Direct mapped cache arrays with hit check and miss replay
// Pops the request FIFO and presents responses in order
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module icache_lookup (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         flush,
    input  logic                         head_valid,
    input  logic [fetch_pkg::addr_w-1:0] head_addr,
    output logic                         pop,
    output logic                         resp_valid,
    input  logic                         resp_ready,
    output logic [fetch_pkg::data_w-1:0] resp_data,
    cache_fill_if.lookup                 fill
);

    ////////////////////////////////////////
    // Cache arrays
    ////////////////////////////////////////

    logic [fetch_pkg::lines-1:0]  line_valid;
    logic [fetch_pkg::tag_w-1:0]  tag_mem [fetch_pkg::lines];
    logic [fetch_pkg::data_w-1:0] data_mem [fetch_pkg::lines];

    // Lookup register, also the held miss entry
    logic                           look_valid;
    fetch_pkg::fetch_addr_t         look_addr;
    logic [fetch_pkg::index_w-1:0]  idx;
    logic                           hit;

    // Refill outstanding, and whether a flush made it stale
    logic                           miss_q;
    logic                           drop_q;
    logic                           fill_write;

    // Offset bits play no part, one word per line
    assign idx = look_addr.fields.index;
    assign hit = look_valid && line_valid[idx] && (tag_mem[idx] == look_addr.fields.tag);

    // A hit is the response, straight from the arrays
    assign resp_valid = hit;
    assign resp_data = data_mem[idx];

    // Take the next head when the register is free or leaving now
    // Held while a refill is in flight
    assign pop = head_valid && !flush && !miss_q
                 && (!look_valid || (resp_valid && resp_ready));

    assign fill.miss_valid = miss_q;
    assign fill.miss_addr = look_addr.word;

    // A fill for a flushed miss is thrown away
    assign fill_write = fill.fill_valid && !drop_q && !flush;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            look_valid <= 1'b0;
            miss_q <= 1'b0;
            drop_q <= 1'b0;
            line_valid <= '0;
        end else begin
            if (flush) look_valid <= 1'b0;
            else if (pop) look_valid <= 1'b1;
            else if (resp_valid && resp_ready) look_valid <= 1'b0;

            // Miss stays up until refill answers
            if (fill.fill_valid) miss_q <= 1'b0;
            else if (look_valid && !hit && !flush) miss_q <= 1'b1;

            if (fill.fill_valid) drop_q <= 1'b0;
            else if (flush && miss_q) drop_q <= 1'b1;

            if (flush) line_valid <= '0;
            else if (fill_write) line_valid[idx] <= 1'b1;
        end
    end

    // Held address and array contents
    always_ff @(posedge aclk) begin
        if (pop) look_addr.word <= head_addr;
        if (fill_write) begin
            tag_mem[idx] <= look_addr.fields.tag;
            data_mem[idx] <= fill.fill_data;
        end
    end

    // Response holds under back-pressure unless flushed
    assert property (@(posedge aclk) disable iff (!aresetn)
        resp_valid && !resp_ready && !flush |=> resp_valid && $stable(resp_data));

    // A word is either answered or being refilled, never both
    assert property (@(posedge aclk) disable iff (!aresetn)
        !(fill.miss_valid && resp_valid));

endmodule

`default_nettype wire

//--- hw/icache_refill.sv
////////////////////////////////////////
// Wishbone classic read master serving one cache miss at a time
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module icache_refill (
    input  logic                         aclk,
    input  logic                         aresetn,
    cache_fill_if.refill                 fill,
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output logic [fetch_pkg::addr_w-1:0] wb_adr,
    input  logic [fetch_pkg::data_w-1:0] wb_dat_i,
    input  logic                         wb_ack
);

    ////////////////////////////////////////
    // Idle, bus and fill states
    ////////////////////////////////////////

    // State bits double as the bus strobe and the fill pulse
    logic                         st_bus;
    logic                         st_fill;
    logic                         st_idle;
    logic                         start;
    logic [fetch_pkg::data_w-1:0] fill_word;

    assign st_idle = !st_bus && !st_fill;
    assign start = st_idle && fill.miss_valid;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            st_bus <= 1'b0;
            st_fill <= 1'b0;
        end else begin
            // Fill lasts one cycle after the ack
            st_fill <= st_bus && wb_ack;
            if (start) st_bus <= 1'b1;
            else if (wb_ack) st_bus <= 1'b0;
        end
    end

    // Address latched at start, word captured on ack
    always_ff @(posedge aclk) begin
        if (start) wb_adr <= fill.miss_addr;
        if (st_bus && wb_ack) fill_word <= wb_dat_i;
    end

    // Read only, cyc and stb move together
    assign wb_cyc = st_bus;
    assign wb_stb = st_bus;
    assign wb_we = 1'b0;

    assign fill.fill_valid = st_fill;
    assign fill.fill_data = fill_word;

    // Classic cycle holds strobe and address until the slave acks
    assert property (@(posedge aclk) disable iff (!aresetn)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

`default_nettype wire

//--- hw/icache_fetch_unit.sv
////////////////////////////////////////
// Instruction fetch unit top, buffer then lookup then refill
// Core port, flush handshake and Wishbone master as plain ports
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module icache_fetch_unit (
    input  logic                         aclk,
    input  logic                         aresetn,
    // Core fetch request and response
    input  logic                         req_valid,
    output logic                         req_ready,
    input  logic [fetch_pkg::addr_w-1:0] req_addr,
    output logic                         resp_valid,
    input  logic                         resp_ready,
    output logic [fetch_pkg::data_w-1:0] resp_data,
    // Flush handshake
    input  logic                         flush_req,
    output logic                         flush_ack,
    // Wishbone classic master
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output logic [fetch_pkg::addr_w-1:0] wb_adr,
    input  logic [fetch_pkg::data_w-1:0] wb_dat_i,
    input  logic                         wb_ack
);

    // FIFO head towards lookup
    logic                         head_valid;
    logic [fetch_pkg::addr_w-1:0] head_addr;
    logic                         pop;
    // One cycle flush at the start of a handshake
    logic                         flush;

    cache_fill_if fill_bus ();

    ////////////////////////////////////////
    // Flush handshake
    ////////////////////////////////////////

    // Ack follows req by one cycle both ways
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) flush_ack <= 1'b0;
        else flush_ack <= flush_req;
    end

    assign flush = flush_req && !flush_ack;

    fetch_req_buffer u_buffer (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .flush      (flush),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .pop        (pop)
    );

    icache_lookup u_lookup (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .flush      (flush),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .pop        (pop),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data),
        .fill       (fill_bus.lookup)
    );

    icache_refill u_refill (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .fill     (fill_bus.refill),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

endmodule

`default_nettype wire

//--- tests/fetch_checker.sv
////////////////////////////////////////
// Watches the fetch unit ports and compares against a cache model
// Top of the testbench loads mem_copy and calls report at the end
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fetch_checker #(
    parameter int mem_words = 64
) (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         req_valid,
    input  logic                         req_ready,
    input  logic [fetch_pkg::addr_w-1:0] req_addr,
    input  logic                         resp_valid,
    input  logic                         resp_ready,
    input  logic [fetch_pkg::data_w-1:0] resp_data,
    input  logic                         flush_req,
    input  logic                         flush_ack,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [fetch_pkg::addr_w-1:0] wb_adr,
    input  logic                         wb_ack,
    output logic                         idle
);

    // Memory image holding the same words as the bus model
    logic [fetch_pkg::data_w-1:0] mem_copy [mem_words];

    // Accepted but unanswered requests with the oldest first
    logic [fetch_pkg::addr_w-1:0] pend_q [$];
    // Bus reads finished since the last response
    logic [fetch_pkg::addr_w-1:0] reads_q [$];

    // Mirror of valid bits and tags
    logic [fetch_pkg::lines-1:0]  line_ok;
    logic [fetch_pkg::tag_w-1:0]  line_tag [fetch_pkg::lines];

    // A flushed miss may still finish one read
    logic stale_ok;
    logic after_flush;

    int n_accept;
    int n_flushed;
    int n_flush;
    int n_resp;
    int n_taken;
    int n_hit;
    int n_miss;
    int n_conflict;
    int err_data;
    int err_read;
    int err_flush;
    int err_count;

    ////////////////////////////////////////
    // Sampling at mid cycle where ports are settled
    ////////////////////////////////////////

    // Values seen here are the ones taken at the next rising edge
    always @(negedge aclk) begin : watch
        fetch_pkg::fetch_addr_t       fa;
        logic [fetch_pkg::data_w-1:0] expect_data;
        logic                         hit;
        int                           limit;
        if (!aresetn) begin
            pend_q.delete();
            reads_q.delete();
            line_ok = '0;
            stale_ok = 1'b0;
            after_flush = 1'b0;
            n_accept = 0;
            n_flushed = 0;
            n_flush = 0;
            n_resp = 0;
            n_taken = 0;
            n_hit = 0;
            n_miss = 0;
            n_conflict = 0;
            err_data = 0;
            err_read = 0;
            err_flush = 0;
            err_count = 0;
            idle = 1'b1;
        end else begin
            // Lookup register is emptied by the flush edge
            if (after_flush && resp_valid) begin
                err_flush++;
                $display("Response presented in the cycle after a flush");
            end
            after_flush = 1'b0;

            if (wb_cyc && wb_stb && wb_ack) begin
                reads_q.push_back(wb_adr);
                // The master only ever reads
                if (wb_we !== 1'b0) begin
                    err_read++;
                    $display("error wb_we expected %h actual %h", 1'b0, wb_we);
                end
            end

            if (resp_valid && resp_ready) begin
                n_taken++;
                if (pend_q.size() == 0) begin
                    err_count++;
                    $display("Response given with no request pending");
                end else begin
                    fa.word = pend_q.pop_front();
                    expect_data = mem_copy[fa.word[fetch_pkg::offset_w +: $clog2(mem_words)]];
                    n_resp++;
                    if (resp_data !== expect_data) begin
                        err_data++;
                        $display("error resp_data expected %h actual %h", expect_data, resp_data);
                    end
                    // Hit is decided by the state before this fetch
                    hit = line_ok[fa.fields.index]
                          && (line_tag[fa.fields.index] == fa.fields.tag);
                    limit = stale_ok ? 2 : 1;
                    if (hit) begin
                        n_hit++;
                        if (reads_q.size() != 0) begin
                            err_read++;
                            $display("Hit on address %h still made %0d bus reads",
                                     fa.word, reads_q.size());
                        end
                    end else begin
                        // Valid line with another tag means a conflict
                        if (line_ok[fa.fields.index]) n_conflict++;
                        else n_miss++;
                        if (reads_q.size() == 0 || reads_q.size() > limit) begin
                            err_read++;
                            $display("Miss on address %h made %0d bus reads",
                                     fa.word, reads_q.size());
                        end else if (reads_q[reads_q.size()-1] !== fa.word) begin
                            err_read++;
                            $display("error wb_adr expected %h actual %h",
                                     fa.word, reads_q[reads_q.size()-1]);
                        end
                        line_ok[fa.fields.index] = 1'b1;
                        line_tag[fa.fields.index] = fa.fields.tag;
                    end
                    reads_q.delete();
                    stale_ok = 1'b0;
                end
            end

            if (req_valid && req_ready) begin
                pend_q.push_back(req_addr);
                n_accept++;
            end

            // Flush pulse is the first cycle of the handshake
            if (flush_req && !flush_ack) begin
                n_flush++;
                n_flushed += pend_q.size();
                pend_q.delete();
                reads_q.delete();
                line_ok = '0;
                stale_ok = 1'b1;
                after_flush = 1'b1;
            end
            idle = (pend_q.size() == 0);
        end
    end

    ////////////////////////////////////////
    // Closing summary
    ////////////////////////////////////////

    task automatic report(output int total);
        if (pend_q.size() != 0 || n_taken != n_accept - n_flushed) begin
            err_count++;
            $display("Got %0d responses for %0d accepted and %0d flushed requests",
                     n_taken, n_accept, n_flushed);
        end
        $display("test responses in order: %0d checked, %0d errors", n_resp, err_data);
        $display("test bus reads: %0d misses, %0d conflicts, %0d hits, %0d errors",
                 n_miss, n_conflict, n_hit, err_read);
        $display("test flush: %0d flushes, %0d requests dropped, %0d errors",
                 n_flush, n_flushed, err_flush);
        $display("test response count: %0d accepted, %0d answered, %0d errors",
                 n_accept, n_taken, err_count);
        total = err_data + err_read + err_flush + err_count;
        // Data and reads per response plus one per flush and one final count
        $display("%0d checks, %0d errors", 2 * n_resp + n_flush + 1, total);
    endtask

endmodule

`default_nettype wire

//--- tests/icache_fetch_unit_tb.sv
////////////////////////////////////////
// Random fetch traffic with flushes against a Wishbone memory model
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module icache_fetch_unit_tb;

    localparam int          period = 40;
    localparam int          reset_cycles = 16;
    localparam int          num_reqs = 300;
    localparam int          mem_words = 64;
    localparam logic [31:0] seed = 32'hffff;
    // Galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] taps = 32'h80200003;

    logic                         aclk;
    logic                         aresetn;
    logic                         req_valid;
    logic                         req_ready;
    logic [fetch_pkg::addr_w-1:0] req_addr;
    logic                         resp_valid;
    logic                         resp_ready;
    logic [fetch_pkg::data_w-1:0] resp_data;
    logic                         flush_req;
    logic                         flush_ack;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [fetch_pkg::addr_w-1:0] wb_adr;
    logic [fetch_pkg::data_w-1:0] wb_dat_i;
    logic                         wb_ack;

    logic [fetch_pkg::data_w-1:0] mem [mem_words];
    logic [31:0]                  lfsr;
    logic                         req_fire;
    logic                         chk_idle;
    logic                         bus_busy;
    int                           ack_wait;
    int                           sent;

    icache_fetch_unit dut (
        .aclk (aclk), .aresetn (aresetn),
        .req_valid (req_valid), .req_ready (req_ready), .req_addr (req_addr),
        .resp_valid (resp_valid), .resp_ready (resp_ready), .resp_data (resp_data),
        .flush_req (flush_req), .flush_ack (flush_ack),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_i (wb_dat_i), .wb_ack (wb_ack)
    );

    fetch_checker #(.mem_words(mem_words)) chk (
        .aclk (aclk), .aresetn (aresetn),
        .req_valid (req_valid), .req_ready (req_ready), .req_addr (req_addr),
        .resp_valid (resp_valid), .resp_ready (resp_ready), .resp_data (resp_data),
        .flush_req (flush_req), .flush_ack (flush_ack),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_ack (wb_ack),
        .idle (chk_idle)
    );

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ taps) : (s >> 1);
    endfunction

    // One step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Core side request held until taken
    task automatic drive_core();
        logic [31:0] r;
        if (req_fire) req_valid = 1'b0;
        if (!req_valid && sent < num_reqs) begin
            draw_bits(2, r);
            if (r != 0) begin
                draw_bits($clog2(mem_words), r);
                req_addr = r << fetch_pkg::offset_w;
                req_valid = 1'b1;
                sent++;
            end
        end
        draw_bits(2, r);
        resp_ready = (r != 0);
        // Rare flush that drops once acknowledged
        if (flush_req && flush_ack) begin
            flush_req = 1'b0;
        end else if (!flush_req && !flush_ack && sent < num_reqs) begin
            draw_bits(7, r);
            flush_req = (r == 0);
        end
    endtask

    // Memory slave acking after 0 to 3 wait cycles
    task automatic drive_bus();
        logic [31:0] r;
        if (wb_ack) begin
            wb_ack = 1'b0;
            bus_busy = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!bus_busy) begin
                draw_bits(2, r);
                ack_wait = r;
                bus_busy = 1'b1;
            end
            if (ack_wait == 0) begin
                wb_ack = 1'b1;
                wb_dat_i = mem[wb_adr[fetch_pkg::offset_w +: $clog2(mem_words)]];
            end else begin
                ack_wait--;
            end
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever #(period / 2) aclk = ~aclk;
    end

    // Request taken at the coming edge
    always @(negedge aclk) req_fire <= req_valid && req_ready;

    initial begin
        logic [31:0] word;
        int          errors;
        lfsr = seed;
        aresetn = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        resp_ready = 1'b0;
        flush_req = 1'b0;
        wb_dat_i = '0;
        wb_ack = 1'b0;
        bus_busy = 1'b0;
        ack_wait = 0;
        sent = 0;
        for (int i = 0; i < mem_words; i++) begin
            draw_bits(32, word);
            mem[i] = word;
            chk.mem_copy[i] = word;
        end
        repeat (reset_cycles) @(posedge aclk);
        #2 aresetn = 1'b1;
        // Run until every request is out and answered or flushed
        while (sent < num_reqs || req_valid || !chk_idle || flush_req || flush_ack || wb_cyc) begin
            @(posedge aclk);
            #2;
            drive_core();
            drive_bus();
        end
        chk.report(errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog allowing 400 cycles per request
    initial begin
        #(period * (reset_cycles + 400 * num_reqs));
        $display("Run timed out before all requests were answered");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_fetch_unit.f
hw/fetch_pkg.sv
hw/cache_fill_if.sv
hw/fetch_req_buffer.sv
hw/icache_lookup.sv
hw/icache_refill.sv
hw/icache_fetch_unit.sv
tests/fetch_checker.sv
tests/icache_fetch_unit_tb.sv

//--- Bender.yml
package:
  name: icache_fetch_unit

sources:
  - hw/fetch_pkg.sv
  - hw/cache_fill_if.sv
  - hw/fetch_req_buffer.sv
  - hw/icache_lookup.sv
  - hw/icache_refill.sv
  - hw/icache_fetch_unit.sv
  - target: test
    files:
      - tests/fetch_checker.sv
      - tests/icache_fetch_unit_tb.sv
